// ==== common/fp_pkg.sv ====
// FP32 field layout, class mask bit positions, status flags and canonical NaN
package fp_pkg;

    // --------------------
    // FP32 word format
    // --------------------
    localparam int unsigned FP_WIDTH  = 32;
    localparam int unsigned EXP_WIDTH = 8;
    localparam int unsigned MAN_WIDTH = 23;

    typedef struct packed {
        logic                 sign;     // Bit 31
        logic [EXP_WIDTH-1:0] exponent; // Biased, all ones for inf and NaN
        logic [MAN_WIDTH-1:0] mantissa; // MSB set marks a quiet NaN
    } fp32_t;

    // Quiet NaN, positive sign, only the quiet bit set in the mantissa
    localparam logic [FP_WIDTH-1:0] CANONICAL_NAN = 32'h7fc0_0000;

    // --------------------
    // Class mask
    // --------------------
    localparam int unsigned NUM_CLASSES = 10;

    typedef logic [NUM_CLASSES-1:0] class_mask_t;

    // Bit positions follow the RISC-V fclass layout
    localparam int unsigned CLS_NEG_INF  = 0;
    localparam int unsigned CLS_NEG_NORM = 1;
    localparam int unsigned CLS_NEG_SUB  = 2;
    localparam int unsigned CLS_NEG_ZERO = 3;
    localparam int unsigned CLS_POS_ZERO = 4;
    localparam int unsigned CLS_POS_SUB  = 5;
    localparam int unsigned CLS_POS_NORM = 6;
    localparam int unsigned CLS_POS_INF  = 7;
    localparam int unsigned CLS_SNAN     = 8;
    localparam int unsigned CLS_QNAN     = 9;

    // --------------------
    // Status flags
    // --------------------
    typedef struct packed {
        logic nv; // Bit 4, invalid operation
        logic dz; // Bit 3, divide by zero
        logic of; // Bit 2, overflow
        logic uf; // Bit 1, underflow
        logic nx; // Bit 0, inexact
    } status_t;

endpackage

// ==== common/fpu_op_pkg.sv ====
// Issue and unit operation encodings, sub-op codes, request, decoded and result structs
package fpu_op_pkg;

    // Transaction tag carried from issue to writeback
    localparam int unsigned TAG_WIDTH = 4;

    // --------------------
    // Operations
    // --------------------
    // Issue-stage view, as the issuer names them
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,
        FMIN_MAX = 3'd1,
        FCMP     = 3'd2,
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,
        FMV_X2F  = 3'd5
    } issue_op_e;

    // Unit-side view
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } unit_op_e;

    // Modifier, meaning depends on the unit op
    typedef logic [1:0] sub_op_t;

    localparam sub_op_t SUB_J    = 2'b00; // Sign from b
    localparam sub_op_t SUB_JN   = 2'b01; // Inverted sign of b
    localparam sub_op_t SUB_JX   = 2'b10; // Sign a xor b
    localparam sub_op_t SUB_PASS = 2'b11; // Register moves, a unchanged
    localparam sub_op_t SUB_MIN  = 2'b00;
    localparam sub_op_t SUB_MAX  = 2'b01;
    localparam sub_op_t SUB_LE   = 2'b00;
    localparam sub_op_t SUB_LT   = 2'b01;
    localparam sub_op_t SUB_EQ   = 2'b10;

    // --------------------
    // Transfer structs
    // --------------------
    typedef struct packed {
        issue_op_e              op;
        logic [2:0]             rm;        // Sub-op in the low two bits
        fp_pkg::fp32_t          operand_a;
        fp_pkg::fp32_t          operand_b;
        logic [TAG_WIDTH-1:0]   tag;
    } fpu_req_t;

    typedef struct packed {
        unit_op_e               unit_op;
        sub_op_t                sub_op;
        fp_pkg::fp32_t          operand_a;
        fp_pkg::fp32_t          operand_b;
        logic [TAG_WIDTH-1:0]   tag;
    } fpu_dec_t;

    typedef struct packed {
        logic [fp_pkg::FP_WIDTH-1:0] value;
        fp_pkg::status_t             status;
        logic [TAG_WIDTH-1:0]        tag;
    } fpu_res_t;

endpackage

// ==== fpu_noncomp/fp32_classify.sv ====
// FP32 operand classifier producing the one-hot RISC-V class mask
`timescale 1ns/100ps

module fp32_classify
    import fp_pkg::*;
(
    input  fp32_t       operand_i,
    output class_mask_t class_o
);

    logic exp_ones, exp_zero, man_zero;
    logic is_inf, is_nan, is_sub, is_zero, is_norm;

    assign exp_ones = &operand_i.exponent;
    assign exp_zero = ~|operand_i.exponent;
    assign man_zero = ~|operand_i.mantissa;

    assign is_inf  = exp_ones & man_zero;
    assign is_nan  = exp_ones & ~man_zero;
    assign is_sub  = exp_zero & ~man_zero;     // Denormal range
    assign is_zero = exp_zero & man_zero;
    assign is_norm = ~exp_ones & ~exp_zero;

    always_comb begin : p_mask
        class_o = '0;
        class_o[CLS_NEG_INF]  = is_inf & operand_i.sign;
        class_o[CLS_NEG_NORM] = is_norm & operand_i.sign;
        class_o[CLS_NEG_SUB]  = is_sub & operand_i.sign;
        class_o[CLS_NEG_ZERO] = is_zero & operand_i.sign;
        class_o[CLS_POS_ZERO] = is_zero & ~operand_i.sign;
        class_o[CLS_POS_SUB]  = is_sub & ~operand_i.sign;
        class_o[CLS_POS_NORM] = is_norm & ~operand_i.sign;
        class_o[CLS_POS_INF]  = is_inf & ~operand_i.sign;
        // NaN class ignores the sign, quiet bit picks the kind
        class_o[CLS_SNAN]     = is_nan & ~operand_i.mantissa[MAN_WIDTH-1];
        class_o[CLS_QNAN]     = is_nan & operand_i.mantissa[MAN_WIDTH-1];
    end

endmodule

// ==== fpu_noncomp/fpu_noncomp_unit.sv ====
// Non-computational FP32 unit: sign injection, min/max, compare, classify, stallable pipe
`timescale 1ns/100ps

module fpu_noncomp_unit
    import fp_pkg::*;
    import fpu_op_pkg::*;
#(
    parameter int unsigned PipeDepth = 2
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  fpu_dec_t dec_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output fpu_res_t res_o
);

    fp32_t               op_a, op_b;
    class_mask_t         class_a, class_b;
    logic                a_nan, b_nan, any_nan, any_snan, both_zero;
    logic                a_lt_b, a_eq_b;    // Total order, -0 below +0
    logic                cmp_lt, cmp_eq;    // IEEE compare, signed zeros equal
    logic [FP_WIDTH-1:0] min_max;
    fpu_res_t            res_d;
    logic                stall;
    logic [PipeDepth-1:0] valid_q;
    fpu_res_t            res_q [PipeDepth];

    assign op_a = dec_i.operand_a;
    assign op_b = dec_i.operand_b;

    fp32_classify i_class_a (
        .operand_i (op_a),
        .class_o   (class_a)
    );

    fp32_classify i_class_b (
        .operand_i (op_b),
        .class_o   (class_b)
    );

    // --------------------
    // Operand properties
    // --------------------
    assign a_nan     = class_a[CLS_SNAN] | class_a[CLS_QNAN];
    assign b_nan     = class_b[CLS_SNAN] | class_b[CLS_QNAN];
    assign any_nan   = a_nan | b_nan;
    assign any_snan  = class_a[CLS_SNAN] | class_b[CLS_SNAN];
    assign both_zero = (class_a[CLS_NEG_ZERO] | class_a[CLS_POS_ZERO])
                     & (class_b[CLS_NEG_ZERO] | class_b[CLS_POS_ZERO]);

    always_comb begin : p_order
        if (op_a.sign != op_b.sign) begin
            a_lt_b = op_a.sign;                 // Negative side is smaller
        end else if (op_a.sign) begin
            a_lt_b = {op_a.exponent, op_a.mantissa} > {op_b.exponent, op_b.mantissa};
        end else begin
            a_lt_b = {op_a.exponent, op_a.mantissa} < {op_b.exponent, op_b.mantissa};
        end
    end

    assign a_eq_b = (op_a == op_b);
    assign cmp_lt = a_lt_b & ~both_zero & ~any_nan;
    assign cmp_eq = (a_eq_b | both_zero) & ~any_nan;

    // A single NaN loses to the number
    always_comb begin : p_min_max
        if (a_nan && b_nan) begin
            min_max = CANONICAL_NAN;
        end else if (a_nan) begin
            min_max = op_b;
        end else if (b_nan) begin
            min_max = op_a;
        end else if (a_lt_b ^ (dec_i.sub_op == SUB_MAX)) begin
            min_max = op_a;
        end else begin
            min_max = op_b;
        end
    end

    // --------------------
    // Result select
    // --------------------
    always_comb begin : p_result
        res_d.value  = '0;
        res_d.status = '0;
        res_d.tag    = dec_i.tag;

        unique case (dec_i.unit_op)
            SGNJ: begin
                unique case (dec_i.sub_op)
                    SUB_J:   res_d.value = {op_b.sign, op_a.exponent, op_a.mantissa};
                    SUB_JN:  res_d.value = {~op_b.sign, op_a.exponent, op_a.mantissa};
                    SUB_JX:  res_d.value = {op_a.sign ^ op_b.sign, op_a.exponent, op_a.mantissa};
                    default: res_d.value = op_a;    // Move passthrough
                endcase
            end
            MINMAX: begin
                res_d.value     = min_max;
                res_d.status.nv = any_snan;
            end
            CMP: begin
                unique case (dec_i.sub_op)
                    SUB_LE: begin
                        res_d.value[0]  = cmp_lt | cmp_eq;
                        res_d.status.nv = any_nan;  // Signaling compare
                    end
                    SUB_LT: begin
                        res_d.value[0]  = cmp_lt;
                        res_d.status.nv = any_nan;
                    end
                    SUB_EQ: begin
                        res_d.value[0]  = cmp_eq;
                        res_d.status.nv = any_snan; // Quiet compare
                    end
                    default: ;
                endcase
            end
            CLASSIFY: res_d.value = FP_WIDTH'(class_a);
            default: ;
        endcase
    end

    // --------------------
    // Tagged pipeline
    // --------------------
    // Whole pipe freezes while the last stage waits on writeback
    assign stall      = valid_q[PipeDepth-1] & ~out_ready_i;
    assign in_ready_o = ~stall;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (!stall) begin
            valid_q[0] <= in_valid_i;
            for (int unsigned i = 1; i < PipeDepth; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        if (!stall) begin
            res_q[0] <= res_d;
            for (int unsigned i = 1; i < PipeDepth; i++) begin
                res_q[i] <= res_q[i-1];
            end
        end
    end

    assign out_valid_o = valid_q[PipeDepth-1];
    assign res_o       = res_q[PipeDepth-1];

endmodule

// ==== design/fpu_op_decode.sv ====
// Issue operation to unit operation translation, purely combinational
`timescale 1ns/100ps

module fpu_op_decode
    import fpu_op_pkg::*;
(
    input  fpu_req_t fpu_req_i,
    output fpu_dec_t fpu_dec_o
);

    always_comb begin : p_translate
        // Operands and tag travel untouched
        fpu_dec_o.operand_a = fpu_req_i.operand_a;
        fpu_dec_o.operand_b = fpu_req_i.operand_b;
        fpu_dec_o.tag       = fpu_req_i.tag;

        // Safe default is a plain passthrough
        fpu_dec_o.unit_op = SGNJ;
        fpu_dec_o.sub_op  = SUB_PASS;

        unique case (fpu_req_i.op)
            // J, JN, JX encoded in rm
            FSGNJ: begin
                fpu_dec_o.unit_op = SGNJ;
                fpu_dec_o.sub_op  = fpu_req_i.rm[1:0];
            end
            // MIN or MAX in rm
            FMIN_MAX: begin
                fpu_dec_o.unit_op = MINMAX;
                fpu_dec_o.sub_op  = fpu_req_i.rm[1:0];
            end
            // LE, LT, EQ in rm
            FCMP: begin
                fpu_dec_o.unit_op = CMP;
                fpu_dec_o.sub_op  = fpu_req_i.rm[1:0];
            end
            FCLASS: begin
                fpu_dec_o.unit_op = CLASSIFY;
                fpu_dec_o.sub_op  = '0;         // rm has no meaning here
            end
            // No recoding for FP32 moves, so both are a sign-injection passthrough
            FMV_F2X, FMV_X2F: begin
                fpu_dec_o.unit_op = SGNJ;
                fpu_dec_o.sub_op  = SUB_PASS;
            end
            default: ;
        endcase
    end

endmodule

// ==== design/fpu_issue_buffer.sv ====
// READY/STALL protocol inversion FSM with a one-entry hold register toward the unit
`timescale 1ns/100ps

module fpu_issue_buffer
    import fpu_op_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    input  logic     valid_i,
    output logic     ready_o,
    input  fpu_dec_t dec_i,
    output logic     unit_valid_o,
    input  logic     unit_ready_i,
    output fpu_dec_t unit_dec_o
);

    typedef enum logic {
        READY,
        STALL
    } state_e;

    state_e   state_q, state_d;
    logic     hold_en;      // Capture the live request
    logic     use_hold;     // Present the held request to the unit
    fpu_dec_t hold_q;

    // --------------------
    // Handshake FSM
    // --------------------
    always_comb begin : p_issue_fsm
        ready_o      = 1'b0;
        unit_valid_o = 1'b0;
        hold_en      = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        unique case (state_q)
            READY: begin
                ready_o      = 1'b1;
                unit_valid_o = valid_i;         // Live request straight through
                // Unit busy, park the request and withhold the token
                if (valid_i && !unit_ready_i) begin
                    ready_o = 1'b0;
                    hold_en = 1'b1;
                    state_d = STALL;
                end
            end
            STALL: begin
                unit_valid_o = 1'b1;
                use_hold     = 1'b1;
                // Token goes back to the issuer once the unit takes it
                if (unit_ready_i) begin
                    ready_o = 1'b1;
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        // Flush drops any parked request
        if (flush_i) begin
            state_d = READY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // Hold register, payload only
    always_ff @(posedge clk_i) begin : p_hold
        if (hold_en) begin
            hold_q <= dec_i;
        end
    end

    assign unit_dec_o = use_hold ? hold_q : dec_i;

endmodule

// ==== design/fpu_wrap.sv ====
// FP32 issue wrapper top: decode, issue buffer and non-computational unit
`timescale 1ns/100ps

module fpu_wrap
    import fpu_op_pkg::*;
#(
    parameter int unsigned TagWidth  = 4,
    parameter int unsigned PipeDepth = 2
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    input  logic     fpu_valid_i,
    input  fpu_req_t fpu_req_i,
    output logic     fpu_ready_o,
    output logic     fpu_valid_o,
    output fpu_res_t fpu_res_o,
    input  logic     result_ready_i
);

    fpu_dec_t dec;          // Live decoded request
    fpu_dec_t unit_dec;     // Live or held, toward the unit
    logic     unit_valid;
    logic     unit_ready;

    // Tag fields are sized by the shared structs
    if (TagWidth != TAG_WIDTH) begin : g_tag_width
        $error("TagWidth %0d differs from TAG_WIDTH %0d", TagWidth, TAG_WIDTH);
    end

    fpu_op_decode i_decode (
        .fpu_req_i (fpu_req_i),
        .fpu_dec_o (dec)
    );

    fpu_issue_buffer i_issue_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .valid_i      (fpu_valid_i),
        .ready_o      (fpu_ready_o),
        .dec_i        (dec),
        .unit_valid_o (unit_valid),
        .unit_ready_i (unit_ready),
        .unit_dec_o   (unit_dec)
    );

    fpu_noncomp_unit #(
        .PipeDepth (PipeDepth)
    ) i_noncomp (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .in_valid_i  (unit_valid),
        .in_ready_o  (unit_ready),
        .dec_i       (unit_dec),
        .out_valid_o (fpu_valid_o),
        .out_ready_i (result_ready_i),
        .res_o       (fpu_res_o)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and active-low reset generator
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter time         Period      = 40ns,
    parameter int unsigned ResetCycles = 4
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin : p_clock
        clk_o = 1'b0;
        forever #(Period / 2) clk_o = ~clk_o;   // Free running
    end

    initial begin : p_reset
        rst_no = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        rst_no <= 1'b1;                          // Release on a rising edge
    end

endmodule

// ==== tb/tb_fpu_wrap.sv ====
// Directed tests, reference model and result monitor for the FP32 issue wrapper
`timescale 1ns/100ps

module tb_fpu_wrap
    import fp_pkg::*;
    import fpu_op_pkg::*;
();

    localparam int unsigned PIPE_DEPTH = 2;
    localparam int unsigned TAG_W      = 4;
    localparam int unsigned TIMEOUT    = 64;   // Cycles per wait
    localparam int unsigned NUM_SPEC   = 11;

    // Expected result with the cycle it was accepted in
    typedef struct packed {
        fpu_res_t    res;
        logic [31:0] cycle;
    } expect_t;

    logic     clk, rst_n, flush, req_valid, req_ready, res_valid, res_ready;
    fpu_req_t req;
    fpu_res_t res;

    expect_t                exp_q [$];             // Outstanding results in issue order
    logic [31:0]            cycle_cnt = '0;
    logic [31:0]            lcg_state = 32'hd269;
    logic [TAG_WIDTH-1:0]   tag_cnt   = '0;
    logic                   check_lat = 1'b1;      // Fixed latency expected

    tb_clock_gen #(.Period(40ns), .ResetCycles(4)) i_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    fpu_wrap #(
        .TagWidth  (TAG_W),
        .PipeDepth (PIPE_DEPTH)
    ) dut_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .flush_i        (flush),
        .fpu_valid_i    (req_valid),
        .fpu_req_i      (req),
        .fpu_ready_o    (req_ready),
        .fpu_valid_o    (res_valid),
        .fpu_res_o      (res),
        .result_ready_i (res_ready)
    );

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // --------------------
    // Failure reporting
    // --------------------
    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got) else begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, got);
            stop_on_failure();
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] special_value(input int unsigned idx);
        case (idx)
            0:       return 32'h0000_0000;          // +0
            1:       return 32'h8000_0000;          // -0
            2:       return 32'h7f80_0000;          // +inf
            3:       return 32'hff80_0000;          // -inf
            4:       return 32'h0000_0001;          // Smallest +subnormal
            5:       return 32'h807f_ffff;          // Largest -subnormal
            6:       return 32'h7fc0_0000;          // Quiet NaN
            7:       return 32'h7f80_0001;          // Signaling NaN
            8:       return 32'hffc1_2345;          // Negative quiet NaN with payload
            9:       return 32'h3f80_0000;          // 1.0
            default: return 32'hc049_0fdb;          // -pi
        endcase
    endfunction

    // Half specials, half raw random words
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_rand();
        if (r[9]) begin
            return special_value(r[16:13] % NUM_SPEC);
        end
        return next_rand();
    endfunction

    function automatic fpu_req_t make_req(input issue_op_e op, input logic [2:0] rm,
                                          input logic [31:0] a, input logic [31:0] b);
        fpu_req_t r;
        r.op        = op;
        r.rm        = rm;
        r.operand_a = a;
        r.operand_b = b;
        r.tag       = tag_cnt;
        tag_cnt     = tag_cnt + 1'b1;               // Wraps, order is checked by queue
        return r;
    endfunction

    // --------------------
    // Reference model
    // --------------------
    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != '0);
    endfunction

    function automatic logic is_snan(input logic [31:0] x);
        return is_nan(x) && !x[22];
    endfunction

    function automatic logic is_zero(input logic [31:0] x);
        return x[30:0] == '0;
    endfunction

    // Negatives inverted so unsigned order is numeric order with -0 below +0
    function automatic logic [31:0] order_key(input logic [31:0] x);
        return x[31] ? ~x : (x | 32'h8000_0000);
    endfunction

    function automatic class_mask_t class_of(input logic [31:0] x);
        class_mask_t m;
        m = '0;
        if (is_nan(x)) begin
            m[x[22] ? CLS_QNAN : CLS_SNAN] = 1'b1;
        end else if (x[30:23] == 8'hff) begin
            m[x[31] ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
        end else if (is_zero(x)) begin
            m[x[31] ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
        end else if (x[30:23] == 8'h00) begin
            m[x[31] ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
        end else begin
            m[x[31] ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
        end
        return m;
    endfunction

    function automatic fpu_res_t model(input fpu_req_t r);
        fpu_res_t    e;
        logic [31:0] a, b;
        logic        lt, eq, nan_in;
        a       = r.operand_a;
        b       = r.operand_b;
        e       = '0;
        e.tag   = r.tag;
        nan_in  = is_nan(a) || is_nan(b);
        eq      = (is_zero(a) && is_zero(b)) || (a == b);
        lt      = !(is_zero(a) && is_zero(b)) && (order_key(a) < order_key(b));
        case (r.op)
            FSGNJ: begin
                case (r.rm[1:0])
                    2'd0:    e.value = {b[31], a[30:0]};
                    2'd1:    e.value = {~b[31], a[30:0]};
                    2'd2:    e.value = {a[31] ^ b[31], a[30:0]};
                    default: e.value = a;
                endcase
            end
            FMIN_MAX: begin
                e.status.nv = is_snan(a) || is_snan(b);
                if (is_nan(a) && is_nan(b)) begin
                    e.value = CANONICAL_NAN;
                end else if (is_nan(a)) begin
                    e.value = b;
                end else if (is_nan(b)) begin
                    e.value = a;
                end else if (r.rm[0]) begin
                    e.value = (order_key(a) < order_key(b)) ? b : a;   // Max
                end else begin
                    e.value = (order_key(a) < order_key(b)) ? a : b;   // Min
                end
            end
            FCMP: begin
                case (r.rm[1:0])
                    2'd0:    e.value[0] = !nan_in && (lt || eq);
                    2'd1:    e.value[0] = !nan_in && lt;
                    default: e.value[0] = !nan_in && eq;
                endcase
                // EQ is quiet, LE and LT signal on any NaN
                e.status.nv = (r.rm[1:0] == 2'd2) ? (is_snan(a) || is_snan(b)) : nan_in;
            end
            FCLASS:  e.value = {22'd0, class_of(a)};
            default: e.value = a;                   // Register moves
        endcase
        return e;
    endfunction

    // --------------------
    // Handshake tasks
    // --------------------
    // All tasks start and end in the time slot of a rising edge
    task automatic record_accept(input fpu_req_t r);
        expect_t item;
        item.res   = model(r);
        item.cycle = cycle_cnt;
        exp_q.push_back(item);
    endtask

    task automatic wait_accept(input fpu_req_t r);
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout: fpu_ready_o never rose to accept request with tag %0d", r.tag);
                stop_on_failure();
            end
            @(negedge clk);
        end
        record_accept(r);
        @(posedge clk);                             // The accepting edge
    endtask

    task automatic wait_drain();
        int unsigned waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout: %0d expected results never came back", exp_q.size());
                stop_on_failure();
            end
            @(posedge clk);
        end
    endtask

    task automatic run_single(input fpu_req_t r);
        req_valid <= 1'b1;
        req       <= r;
        wait_accept(r);
        req_valid <= 1'b0;
        wait_drain();
    endtask

    // Checks every transfer toward writeback against the queue front
    always @(negedge clk) begin : p_monitor
        expect_t item;
        if (rst_n && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                $display("Result with tag %0d arrived while nothing was outstanding", res.tag);
                stop_on_failure();
            end
            item = exp_q.pop_front();
            check_value("fpu_res_o.tag", item.res.tag, res.tag);
            check_value("fpu_res_o.value", item.res.value, res.value);
            check_value("fpu_res_o.status", item.res.status, res.status);
            if (check_lat) begin
                check_value("fpu_valid_o latency", PIPE_DEPTH, cycle_cnt - item.cycle);
            end
        end
    end

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_sign_inject();
        logic [31:0] a, b;
        for (int i = 0; i < 12; i++) begin
            a = pick_operand();
            b = pick_operand();
            for (int s = 0; s < 3; s++) begin
                run_single(make_req(FSGNJ, 3'(s), a, b));   // J, JN, JX
            end
            run_single(make_req(FMV_F2X, 3'd0, a, b));
            run_single(make_req(FMV_X2F, 3'd7, a, b));      // rm must not matter
        end
    endtask

    task automatic test_min_max();
        for (int i = 0; i < NUM_SPEC; i++) begin
            for (int j = 0; j < NUM_SPEC; j++) begin
                run_single(make_req(FMIN_MAX, 3'd0, special_value(i), special_value(j)));
                run_single(make_req(FMIN_MAX, 3'd1, special_value(i), special_value(j)));
            end
        end
        repeat (20) run_single(make_req(FMIN_MAX, 3'(next_rand() & 32'd1),
                                        pick_operand(), pick_operand()));
    endtask

    task automatic test_compare();
        logic [31:0] a;
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < NUM_SPEC; i++) begin
                for (int j = 0; j < NUM_SPEC; j++) begin
                    run_single(make_req(FCMP, 3'(s), special_value(i), special_value(j)));
                end
            end
            repeat (10) begin
                a = next_rand();
                run_single(make_req(FCMP, 3'(s), a, a));                 // Equal pair
                run_single(make_req(FCMP, 3'(s), a, pick_operand()));
            end
        end
    endtask

    task automatic test_classify();
        logic [31:0] r;
        for (int i = 0; i < NUM_SPEC; i++) begin
            run_single(make_req(FCLASS, 3'd5, special_value(i), next_rand()));
        end
        repeat (16) begin
            r = next_rand();
            // Keep the exponent inside the normal range
            if (r[30:23] == 8'h00) begin
                r[30:23] = 8'h01;
            end else if (r[30:23] == 8'hff) begin
                r[30:23] = 8'hfe;
            end
            run_single(make_req(FCLASS, 3'd0, r, '0));
        end
    endtask

    task automatic test_back_pressure();
        fpu_req_t    r;
        int unsigned accepted;
        logic        dropped;
        accepted  = 0;
        dropped   = 1'b0;
        check_lat = 1'b0;
        res_ready <= 1'b0;                          // Writeback stalls
        while (!dropped) begin
            r = make_req(FSGNJ, 3'd1, next_rand(), next_rand());
            req_valid <= 1'b1;
            req       <= r;
            @(negedge clk);
            if (req_ready) begin
                record_accept(r);
                accepted++;
                if (accepted > PIPE_DEPTH) begin   // Pipe plus held entry exceeded
                    $display("fpu_ready_o stayed high after %0d accepted requests", accepted);
                    stop_on_failure();
                end
                @(posedge clk);
            end else begin
                dropped = 1'b1;                     // r is now in the hold register
            end
        end
        repeat (4) begin
            @(negedge clk);
            assert (!req_ready && res_valid) else begin
                $display("Stall not held while writeback was blocked");
                stop_on_failure();
            end
        end
        @(posedge clk);
        res_ready <= 1'b1;
        wait_accept(r);                             // Held request enters the unit
        req_valid <= 1'b0;
        wait_drain();
        check_lat = 1'b1;
    endtask

    task automatic test_flush();
        fpu_req_t r;
        check_lat = 1'b0;
        res_ready <= 1'b0;
        for (int i = 0; i < PIPE_DEPTH; i++) begin
            r = make_req(FCLASS, 3'd0, next_rand(), '0);
            req_valid <= 1'b1;
            req       <= r;
            wait_accept(r);
        end
        req <= make_req(FSGNJ, 3'd2, next_rand(), next_rand());
        @(negedge clk);
        assert (!req_ready) else begin
            $display("fpu_ready_o stayed high with the pipeline full");
            stop_on_failure();
        end
        @(posedge clk);
        flush     <= 1'b1;
        req_valid <= 1'b0;
        @(posedge clk);
        flush     <= 1'b0;
        res_ready <= 1'b1;
        exp_q.delete();                             // Flushed results must never show up
        repeat (6) begin
            @(negedge clk);
            assert (!res_valid && req_ready) else begin
                $display("Flushed result appeared or fpu_ready_o stayed low after flush");
                stop_on_failure();
            end
        end
        @(posedge clk);
        check_lat = 1'b1;
        run_single(make_req(FMIN_MAX, 3'd1, pick_operand(), pick_operand()));
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin : p_main
        int unsigned waited;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        res_ready = 1'b1;
        waited    = 0;
        while (rst_n !== 1'b1) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout: reset was never released");
                stop_on_failure();
            end
            @(posedge clk);
        end
        @(negedge clk);
        assert (!res_valid && req_ready) else begin
            $display("Wrong handshake levels after reset");
            stop_on_failure();
        end
        @(posedge clk);
        test_sign_inject();
        test_min_max();
        test_compare();
        test_classify();
        test_back_pressure();
        test_flush();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== project.f ====
common/fp_pkg.sv
common/fpu_op_pkg.sv
fpu_noncomp/fp32_classify.sv
fpu_noncomp/fpu_noncomp_unit.sv
design/fpu_op_decode.sv
design/fpu_issue_buffer.sv
design/fpu_wrap.sv
tb/tb_clock_gen.sv
tb/tb_fpu_wrap.sv
